//--- logic/gbc_settings.svh
`ifndef GBC_SETTINGS_SVH
`define GBC_SETTINGS_SVH

// Bus widths
`define GBC_DATA_W 8
`define GBC_ADDR_W 16

// Interrupt sources, one bit each in IF and IE
`define GBC_IRQ_N 5

// Free-running divider behind DIV
`define GBC_DIV_W 16

// Start of the memory-mapped register page
`define GBC_IO_BASE 16'hFF00

// Divider bit watched for each TAC rate select
`define GBC_TAP_0 9
`define GBC_TAP_1 3
`define GBC_TAP_2 5
`define GBC_TAP_3 7

`endif

//--- logic/gbc_bus_pkg.sv
`default_nettype none

`include "gbc_settings.svh"

package gbc_bus_pkg;

   // ========================================================================
   // CPU side of the router
   // ========================================================================

   typedef struct packed {
      logic [`GBC_ADDR_W-1:0] addr;
      logic [`GBC_DATA_W-1:0] wdata;
      logic                   write;
   } cpu_req_t;

   // Read data only, writes get no response
   typedef struct packed {
      logic [`GBC_DATA_W-1:0] rdata;
   } cpu_rsp_t;

   // ========================================================================
   // Router to register units
   // ========================================================================

   // Strobes are high for the accept cycle only
   typedef struct packed {
      logic [7:0]             addr;
      logic [`GBC_DATA_W-1:0] wdata;
      logic                   wr;
      logic                   rd;
   } io_access_t;

   // Returned combinationally by each unit
   typedef struct packed {
      logic                   hit;
      logic [`GBC_DATA_W-1:0] data;
   } io_read_t;

   typedef enum logic [0:0] {
      ROUTER_IDLE = 1'b0,
      ROUTER_HOLD = 1'b1
   } router_state_e;

endpackage

`default_nettype wire

//--- logic/gbc_io_pkg.sv
`default_nettype none

package gbc_io_pkg;

   // Low byte of each mapped register address
   typedef enum logic [7:0] {
      REG_SB   = 8'h01,
      REG_SC   = 8'h02,
      REG_DIV  = 8'h04,
      REG_TIMA = 8'h05,
      REG_TMA  = 8'h06,
      REG_TAC  = 8'h07,
      REG_IF   = 8'h0F,
      REG_KEY1 = 8'h4D,
      REG_RP   = 8'h56,
      // 0xFFFF arrives with its low byte only
      REG_IE   = 8'hFF
   } io_reg_e;

   // Bit positions in IF and IE, lowest wins
   typedef enum logic [2:0] {
      IRQ_VBLANK  = 3'd0,
      IRQ_LCDSTAT = 3'd1,
      IRQ_TIMER   = 3'd2,
      IRQ_SERIAL  = 3'd3,
      IRQ_JOYPAD  = 3'd4
   } irq_src_e;

   // TAC bits 1..0
   typedef enum logic [1:0] {
      TAC_RATE_4K   = 2'd0,
      TAC_RATE_262K = 2'd1,
      TAC_RATE_65K  = 2'd2,
      TAC_RATE_16K  = 2'd3
   } tac_rate_e;

endpackage

`default_nettype wire

//--- logic/io_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbc_settings.svh"

module io_router (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  gbc_bus_pkg::cpu_req_t   req,
   output logic                    rsp_valid,
   input  logic                    rsp_ready,
   output gbc_bus_pkg::cpu_rsp_t   rsp,
   output gbc_bus_pkg::io_access_t io_acc,
   input  gbc_bus_pkg::io_read_t   timer_rd,
   input  gbc_bus_pkg::io_read_t   intr_rd,
   input  gbc_bus_pkg::io_read_t   scratch_rd
);
   import gbc_bus_pkg::*;

   localparam int ADDR_W = `GBC_ADDR_W;
   localparam int DATA_W = `GBC_DATA_W;
   localparam logic [ADDR_W-1:0] IO_BASE = `GBC_IO_BASE;
   localparam logic [ADDR_W-1:0] IE_ADDR = IO_BASE | 16'h00FF;

   router_state_e     state_q;
   logic              accept;
   logic              io_sel;
   logic              any_hit;
   logic [DATA_W-1:0] merged;
   cpu_rsp_t          rsp_q;

   // One read in flight, new requests wait for the response to drain
   assign req_ready = (state_q == ROUTER_IDLE);
   assign accept    = req_valid && req_ready;

   // Lower half of the I/O page, or the enable byte
   assign io_sel = accept && ((req.addr[ADDR_W-1:7] == IO_BASE[ADDR_W-1:7])
                              || (req.addr == IE_ADDR));

   assign io_acc = '{addr:  req.addr[7:0],
                     wdata: req.wdata,
                     wr:    io_sel && req.write,
                     rd:    io_sel && !req.write};

   // Units drive data only alongside hit
   assign any_hit = timer_rd.hit | intr_rd.hit | scratch_rd.hit;
   assign merged  = ({DATA_W{timer_rd.hit}}   & timer_rd.data)
                  | ({DATA_W{intr_rd.hit}}    & intr_rd.data)
                  | ({DATA_W{scratch_rd.hit}} & scratch_rd.data);

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         state_q <= ROUTER_IDLE;
      end else begin
         case (state_q)
            ROUTER_IDLE: if (accept && !req.write) state_q <= ROUTER_HOLD;
            ROUTER_HOLD: if (rsp_ready) state_q <= ROUTER_IDLE;
            default:     state_q <= ROUTER_IDLE;
         endcase
      end
   end

   // Response payload, unmapped reads float high
   always_ff @(posedge clock_in) begin
      if (accept && !req.write) begin
         rsp_q.rdata <= any_hit ? merged : {DATA_W{1'b1}};
      end
   end

   assign rsp_valid = (state_q == ROUTER_HOLD);
   assign rsp       = rsp_q;

   a_rsp_held: assert property (@(posedge clock_in) disable iff (synch_reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

   // Address decode in the three units must not overlap
   a_one_hit: assert property (@(posedge clock_in) disable iff (synch_reset)
      $onehot0({timer_rd.hit, intr_rd.hit, scratch_rd.hit}));

endmodule

`default_nettype wire

//--- logic/timer_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbc_settings.svh"

module timer_unit (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  gbc_bus_pkg::io_access_t io_acc,
   output gbc_bus_pkg::io_read_t   rd,
   output logic                    timer_irq
);
   import gbc_bus_pkg::*;
   import gbc_io_pkg::*;

   localparam int DIV_W  = `GBC_DIV_W;
   localparam int DATA_W = `GBC_DATA_W;

   logic [DIV_W-1:0]  div_q;
   logic [DATA_W-1:0] tima_q;
   logic [DATA_W-1:0] tma_q;
   logic [2:0]        tac_q;
   tac_rate_e         rate;
   logic              tap;
   logic              tap_q;
   logic              tick;
   logic              overflow;
   logic              wr_div;
   logic              wr_tima;
   logic              wr_tma;
   logic              wr_tac;

   assign wr_div  = io_acc.wr && (io_acc.addr == REG_DIV);
   assign wr_tima = io_acc.wr && (io_acc.addr == REG_TIMA);
   assign wr_tma  = io_acc.wr && (io_acc.addr == REG_TMA);
   assign wr_tac  = io_acc.wr && (io_acc.addr == REG_TAC);

   // ========================================================================
   // Rate tap and edge detect
   // ========================================================================

   assign rate = tac_rate_e'(tac_q[1:0]);

   always_comb begin
      case (rate)
         TAC_RATE_4K:   tap = div_q[`GBC_TAP_0];
         TAC_RATE_262K: tap = div_q[`GBC_TAP_1];
         TAC_RATE_65K:  tap = div_q[`GBC_TAP_2];
         default:       tap = div_q[`GBC_TAP_3];
      endcase
   end

   // Falling edge of the tap, counted only while enabled
   assign tick     = tac_q[2] && tap_q && !tap;
   // A CPU write to TIMA in the same cycle cancels the reload
   assign overflow = tick && (tima_q == {DATA_W{1'b1}}) && !wr_tima;

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         div_q     <= '0;
         tima_q    <= '0;
         tma_q     <= '0;
         tac_q     <= '0;
         tap_q     <= 1'b0;
         timer_irq <= 1'b0;
      end else begin
         div_q     <= wr_div ? '0 : div_q + 1'b1;
         tap_q     <= tap;
         timer_irq <= overflow;
         if (wr_tima) begin
            tima_q <= io_acc.wdata;
         end else if (overflow) begin
            tima_q <= tma_q;
         end else if (tick) begin
            tima_q <= tima_q + 1'b1;
         end
         if (wr_tma) tma_q <= io_acc.wdata;
         if (wr_tac) tac_q <= io_acc.wdata[2:0];
      end
   end

   // Read side, DIV shows the top byte of the counter
   always_comb begin
      rd.hit = io_acc.rd;
      case (io_acc.addr)
         REG_DIV:  rd.data = div_q[DIV_W-1 -: DATA_W];
         REG_TIMA: rd.data = tima_q;
         REG_TMA:  rd.data = tma_q;
         REG_TAC:  rd.data = {5'b11111, tac_q};
         default: begin
            rd.hit  = 1'b0;
            rd.data = '0;
         end
      endcase
   end

   a_irq_single: assert property (@(posedge clock_in) disable iff (synch_reset)
      timer_irq |=> !timer_irq);

endmodule

`default_nettype wire

//--- logic/interrupt_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbc_settings.svh"

module interrupt_unit (
   input  logic                     clock_in,
   input  logic                     synch_reset,
   input  gbc_bus_pkg::io_access_t  io_acc,
   output gbc_bus_pkg::io_read_t    rd,
   input  logic                     timer_irq,
   input  logic [`GBC_IRQ_N-1:0]    ext_irq,
   output logic                     irq_valid,
   output gbc_io_pkg::irq_src_e     irq_src
);
   import gbc_bus_pkg::*;
   import gbc_io_pkg::*;

   localparam int IRQ_N = `GBC_IRQ_N;

   logic [IRQ_N-1:0] if_q;
   logic [IRQ_N-1:0] ie_q;
   logic [IRQ_N-1:0] set_req;
   logic [IRQ_N-1:0] pend;
   irq_src_e         src_next;
   logic             wr_if;
   logic             wr_ie;

   assign wr_if = io_acc.wr && (io_acc.addr == REG_IF);
   assign wr_ie = io_acc.wr && (io_acc.addr == REG_IE);

   // Timer slot comes from the timer unit, not the external vector
   always_comb begin
      set_req            = ext_irq;
      set_req[IRQ_TIMER] = timer_irq;
   end

   assign pend = if_q & ie_q;

   // Lowest set bit wins, so scan from the top down
   always_comb begin
      src_next = IRQ_VBLANK;
      for (int i = IRQ_N - 1; i >= 0; i--) begin
         if (pend[i]) src_next = irq_src_e'(3'(i));
      end
   end

   always_ff @(posedge clock_in) begin
      if (synch_reset) begin
         if_q      <= '0;
         ie_q      <= '0;
         irq_valid <= 1'b0;
         irq_src   <= IRQ_VBLANK;
      end else begin
         // Sets win over a CPU clear in the same cycle
         if_q      <= (wr_if ? io_acc.wdata[IRQ_N-1:0] : if_q) | set_req;
         if (wr_ie) ie_q <= io_acc.wdata[IRQ_N-1:0];
         irq_valid <= |pend;
         irq_src   <= src_next;
      end
   end

   always_comb begin
      rd.hit = io_acc.rd;
      case (io_acc.addr)
         REG_IF:  rd.data = {3'b111, if_q};
         REG_IE:  rd.data = {3'b000, ie_q};
         default: begin
            rd.hit  = 1'b0;
            rd.data = '0;
         end
      endcase
   end

   // irq_valid lags IF and IE by one cycle
   a_src_pending: assert property (@(posedge clock_in) disable iff (synch_reset)
      irq_valid |-> |($past(pend) & ({{(IRQ_N-1){1'b0}}, 1'b1} << irq_src)));

endmodule

`default_nettype wire

//--- logic/scratch_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_regs (
   input  logic                    clock_in,
   input  logic                    synch_reset,
   input  gbc_bus_pkg::io_access_t io_acc,
   output gbc_bus_pkg::io_read_t   rd
);
   import gbc_bus_pkg::*;
   import gbc_io_pkg::*;

   localparam int NREGS = 4;

   // Slot order SB, SC, KEY1, RP from index 0 up
   localparam logic [NREGS-1:0][7:0] REG_ADDR = {REG_RP, REG_KEY1, REG_SC, REG_SB};
   localparam logic [NREGS-1:0][7:0] REG_INIT = {8'h3E, 8'hFD, 8'h7C, 8'h00};

   logic [NREGS-1:0][7:0] regs_q;

   always_ff @(posedge clock_in) begin
      for (int i = 0; i < NREGS; i++) begin
         if (synch_reset) begin
            regs_q[i] <= REG_INIT[i];
         end else if (io_acc.wr && (io_acc.addr == REG_ADDR[i])) begin
            regs_q[i] <= io_acc.wdata;
         end
      end
   end

   // Plain storage, read back as written
   always_comb begin
      rd.hit  = 1'b0;
      rd.data = '0;
      for (int i = 0; i < NREGS; i++) begin
         if (io_acc.rd && (io_acc.addr == REG_ADDR[i])) begin
            rd.hit  = 1'b1;
            rd.data = regs_q[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/gbc_io_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbc_settings.svh"

module gbc_io_top (
   input  logic                  clock_in,
   input  logic                  synch_reset,
   input  logic                  req_valid,
   output logic                  req_ready,
   input  gbc_bus_pkg::cpu_req_t req,
   output logic                  rsp_valid,
   input  logic                  rsp_ready,
   output gbc_bus_pkg::cpu_rsp_t rsp,
   input  logic [`GBC_IRQ_N-1:0] ext_irq,
   output logic                  irq_valid,
   output gbc_io_pkg::irq_src_e  irq_src
);
   import gbc_bus_pkg::*;

   io_access_t io_acc;
   io_read_t   timer_rd;
   io_read_t   intr_rd;
   io_read_t   scratch_rd;
   logic       timer_irq;

   // ========================================================================
   // Request router and the three register units
   // ========================================================================

   io_router router_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req         (req),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp         (rsp),
      .io_acc      (io_acc),
      .timer_rd    (timer_rd),
      .intr_rd     (intr_rd),
      .scratch_rd  (scratch_rd)
   );

   timer_unit timer_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_acc      (io_acc),
      .rd          (timer_rd),
      .timer_irq   (timer_irq)
   );

   interrupt_unit intr_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_acc      (io_acc),
      .rd          (intr_rd),
      .timer_irq   (timer_irq),
      .ext_irq     (ext_irq),
      .irq_valid   (irq_valid),
      .irq_src     (irq_src)
   );

   scratch_regs scratch_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .io_acc      (io_acc),
      .rd          (scratch_rd)
   );

endmodule

`default_nettype wire

//--- tb/gbc_io_model.svh
`ifndef GBC_IO_MODEL_SVH
`define GBC_IO_MODEL_SVH

// Expected register contents, updated on every accepted write
logic [7:0]            m_sb;
logic [7:0]            m_sc;
logic [7:0]            m_key1;
logic [7:0]            m_rp;
logic [7:0]            m_tima;
logic [7:0]            m_tma;
logic [2:0]            m_tac;
logic [`GBC_IRQ_N-1:0] m_if;
logic [`GBC_IRQ_N-1:0] m_ie;

function automatic void model_reset();
   m_sb   = 8'h00;
   m_sc   = 8'h7C;
   m_key1 = 8'hFD;
   m_rp   = 8'h3E;
   m_tima = 8'h00;
   m_tma  = 8'h00;
   m_tac  = 3'b000;
   m_if   = '0;
   m_ie   = '0;
endfunction

function automatic logic [15:0] reg_addr(input io_reg_e r);
   return `GBC_IO_BASE | {8'h00, r};
endfunction

// Lower half of the I/O page plus the enable byte
function automatic bit in_io_space(input logic [15:0] addr);
   return (addr >= 16'hFF00 && addr <= 16'hFF7F) || (addr == 16'hFFFF);
endfunction

function automatic bit is_mapped(input logic [7:0] low);
   case (low)
      REG_SB, REG_SC, REG_DIV, REG_TIMA, REG_TMA, REG_TAC,
      REG_IF, REG_KEY1, REG_RP, REG_IE: return 1'b1;
      default: return 1'b0;
   endcase
endfunction

function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
   if (in_io_space(addr)) begin
      case (addr[7:0])
         REG_SB:   m_sb   = data;
         REG_SC:   m_sc   = data;
         REG_KEY1: m_key1 = data;
         REG_RP:   m_rp   = data;
         REG_TIMA: m_tima = data;
         REG_TMA:  m_tma  = data;
         REG_TAC:  m_tac  = data[2:0];
         REG_IF:   m_if   = data[`GBC_IRQ_N-1:0];
         REG_IE:   m_ie   = data[`GBC_IRQ_N-1:0];
         // DIV restarts, other bytes ignored
         default: ;
      endcase
   end
endfunction

function automatic logic [7:0] model_read(input logic [15:0] addr);
   if (!in_io_space(addr)) return 8'hFF;
   case (addr[7:0])
      REG_SB:   return m_sb;
      REG_SC:   return m_sc;
      REG_KEY1: return m_key1;
      REG_RP:   return m_rp;
      // Holds only within 256 cycles of a DIV write
      REG_DIV:  return 8'h00;
      REG_TIMA: return m_tima;
      REG_TMA:  return m_tma;
      REG_TAC:  return {5'b11111, m_tac};
      REG_IF:   return {3'b111, m_if};
      REG_IE:   return {3'b000, m_ie};
      default:  return 8'hFF;
   endcase
endfunction

// Lowest numbered source wins
function automatic irq_src_e lowest_pending(input logic [`GBC_IRQ_N-1:0] pend);
   irq_src_e src;
   bit       found;
   src   = IRQ_VBLANK;
   found = 1'b0;
   for (int i = 0; i < `GBC_IRQ_N; i++) begin
      if (!found && pend[i]) begin
         src   = irq_src_e'(i[2:0]);
         found = 1'b1;
      end
   end
   return src;
endfunction

`endif

//--- tb/tb_gbc_io.sv
`timescale 1ns/1ps
`default_nettype none

`include "gbc_settings.svh"

module tb_gbc_io;
   import gbc_bus_pkg::*;
   import gbc_io_pkg::*;

   localparam int TIMEOUT        = 200;
   localparam int POLL_LIMIT     = 40;
   localparam int DIV_POLL_LIMIT = 200;
   // External vector without the timer slot
   localparam logic [`GBC_IRQ_N-1:0] EXT_MASK = 5'b11011;

   logic                  clock_in;
   logic                  synch_reset;
   logic                  req_valid;
   logic                  req_ready;
   cpu_req_t              req;
   logic                  rsp_valid;
   logic                  rsp_ready;
   cpu_rsp_t              rsp;
   logic [`GBC_IRQ_N-1:0] ext_irq;
   logic                  irq_valid;
   irq_src_e              irq_src;

   integer seed;
   int     checks;
   int     errors;
   int     mark_checks;
   int     mark_errors;

   `include "gbc_io_model.svh"

   gbc_io_top dut_i (
      .clock_in    (clock_in),
      .synch_reset (synch_reset),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req         (req),
      .rsp_valid   (rsp_valid),
      .rsp_ready   (rsp_ready),
      .rsp         (rsp),
      .ext_irq     (ext_irq),
      .irq_valid   (irq_valid),
      .irq_src     (irq_src)
   );

   always #20 clock_in = ~clock_in;

   // ========================================================================
   // Random numbers, checks and reporting
   // ========================================================================

   function automatic logic [31:0] rand32();
      logic [31:0] r;
      r = $random(seed);
      return r;
   endfunction

   function automatic logic [7:0] rand8();
      logic [31:0] r;
      r = rand32();
      return r[7:0];
   endfunction

   task automatic note_failure(input string why);
      errors++;
      $display("%s", why);
   endtask

   task automatic check_rsp(input string what, input cpu_rsp_t got, input cpu_rsp_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: rsp.rdata for %s got 0x%02h expected 0x%02h",
                  $time, what, got.rdata, exp.rdata);
      end
   endtask

   task automatic check_irq(input irq_src_e got, input irq_src_e exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t ns: irq_src got %s expected %s",
                  $time, got.name(), exp.name());
      end
   endtask

   task automatic begin_test();
      mark_checks = checks;
      mark_errors = errors;
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - mark_checks, errors - mark_errors);
   endtask

   // ========================================================================
   // Bus transactions
   // ========================================================================

   // Returns just after the edge on which the request transferred
   task automatic send_request(input cpu_req_t r, output bit ok);
      int waited;
      @(posedge clock_in);
      req_valid <= 1'b1;
      req       <= r;
      waited = 0;
      ok     = 1'b0;
      while (!ok && waited < TIMEOUT) begin
         @(negedge clock_in);
         if (req_ready) ok = 1'b1;
         else waited++;
      end
      @(posedge clock_in);
      req_valid <= 1'b0;
      if (!ok) note_failure($sformatf("timeout: request to %04h never accepted", r.addr));
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      cpu_req_t r;
      bit       ok;
      r = '{addr: addr, wdata: data, write: 1'b1};
      send_request(r, ok);
      if (ok) model_write(addr, data);
   endtask

   task automatic bus_read(input logic [15:0] addr, output cpu_rsp_t got, output bit ok);
      cpu_req_t r;
      int       waited;
      bit       taken;
      logic [31:0] rnd;
      r = '{addr: addr, wdata: 8'h00, write: 1'b0};
      got = '0;
      send_request(r, ok);
      if (ok) begin
         waited = 0;
         taken  = 1'b0;
         rnd = rand32();
         rsp_ready <= (rnd[1:0] != 2'b00);
         while (!taken && waited < TIMEOUT) begin
            @(negedge clock_in);
            if (rsp_valid && rsp_ready) begin
               got   = rsp;
               taken = 1'b1;
            end else begin
               waited++;
               @(posedge clock_in);
               rnd = rand32();
               // Ready low about a quarter of the time
               rsp_ready <= (rnd[1:0] != 2'b00);
            end
         end
         @(posedge clock_in);
         rsp_ready <= 1'b0;
         ok = taken;
         if (!taken) note_failure($sformatf("timeout: no response to read of %04h", addr));
      end
   endtask

   task automatic read_and_check(input logic [15:0] addr);
      cpu_rsp_t got;
      cpu_rsp_t exp;
      bit       ok;
      bus_read(addr, got, ok);
      exp.rdata = model_read(addr);
      if (ok) check_rsp($sformatf("%04h", addr), got, exp);
   endtask

   task automatic wait_irq_level(input logic level, output bit ok);
      int waited;
      waited = 0;
      ok     = 1'b0;
      while (!ok && waited < TIMEOUT) begin
         @(negedge clock_in);
         if (irq_valid === level) ok = 1'b1;
         else waited++;
      end
   endtask

   // Scratch registers, TMA, IE, unmapped bytes and addresses off the page
   function automatic logic [15:0] pick_addr();
      logic [31:0] r;
      logic [7:0]  low;
      logic [15:0] addr;
      r = rand32();
      case (r[2:0])
         3'd0: addr = reg_addr(REG_SB);
         3'd1: addr = reg_addr(REG_SC);
         3'd2: addr = reg_addr(REG_KEY1);
         3'd3: addr = reg_addr(REG_RP);
         3'd4: addr = reg_addr(REG_TMA);
         3'd5: addr = reg_addr(REG_IE);
         3'd6: begin
            low = {1'b0, r[14:8]};
            if (is_mapped(low)) low = 8'h03;
            addr = {8'hFF, low};
         end
         default: addr = {1'b0, r[30:16]};
      endcase
      return addr;
   endfunction

   // ========================================================================
   // Test sequence
   // ========================================================================

   initial begin
      cpu_rsp_t              got;
      cpu_rsp_t              exp;
      bit                    ok;
      bit                    seen;
      int                    polls;
      logic [31:0]           r;
      logic [15:0]           addr;
      logic [`GBC_IRQ_N-1:0] ext;
      logic [`GBC_IRQ_N-1:0] ie;
      logic [`GBC_IRQ_N-1:0] pend;

      clock_in    = 1'b0;
      synch_reset = 1'b1;
      req_valid   = 1'b0;
      req         = '0;
      rsp_ready   = 1'b0;
      ext_irq     = '0;
      seed        = 32'hf04b;
      checks      = 0;
      errors      = 0;
      model_reset();
      repeat (2) @(posedge clock_in);
      synch_reset <= 1'b0;

      begin_test();
      read_and_check(reg_addr(REG_SB));
      read_and_check(reg_addr(REG_SC));
      read_and_check(reg_addr(REG_KEY1));
      read_and_check(reg_addr(REG_RP));
      read_and_check(reg_addr(REG_IF));
      read_and_check(reg_addr(REG_IE));
      read_and_check(reg_addr(REG_TIMA));
      read_and_check(reg_addr(REG_TMA));
      read_and_check(reg_addr(REG_TAC));
      end_test(1, "reset values");

      begin_test();
      for (int n = 0; n < 80; n++) begin
         addr = pick_addr();
         r = rand32();
         if (r[0]) bus_write(addr, r[15:8]);
         else read_and_check(addr);
      end
      end_test(2, "random access");

      begin_test();
      for (int n = 0; n < 3; n++) begin
         // Let the divider carry into its upper byte first
         polls = 0;
         seen  = 1'b0;
         while (!seen && polls < DIV_POLL_LIMIT) begin
            bus_read(reg_addr(REG_DIV), got, ok);
            if (ok && got.rdata != 8'h00) seen = 1'b1;
            else polls++;
         end
         if (!seen) note_failure("DIV upper byte never moved off zero");
         bus_write(reg_addr(REG_DIV), rand8());
         read_and_check(reg_addr(REG_DIV));
      end
      end_test(3, "divider clear");

      begin_test();
      bus_write(reg_addr(REG_IF), 8'h00);
      bus_write(reg_addr(REG_TMA), rand8());
      bus_write(reg_addr(REG_TIMA), 8'hFF);
      bus_write(reg_addr(REG_TAC), {6'b000001, TAC_RATE_262K});
      polls = 0;
      seen  = 1'b0;
      while (!seen && polls < POLL_LIMIT) begin
         bus_read(reg_addr(REG_IF), got, ok);
         if (ok && got.rdata[IRQ_TIMER]) seen = 1'b1;
         else polls++;
      end
      if (seen) begin
         m_if[IRQ_TIMER] = 1'b1;
         exp.rdata = model_read(reg_addr(REG_IF));
         check_rsp("IF after overflow", got, exp);
      end else begin
         note_failure("timer overflow never set the timer bit in IF");
      end
      bus_write(reg_addr(REG_TAC), 8'h00);
      bus_read(reg_addr(REG_TIMA), got, ok);
      if (ok) begin
         checks++;
         if (got.rdata < m_tma) begin
            errors++;
            $display("error at %0t ns: rsp.rdata for TIMA got 0x%02h expected at least 0x%02h",
                     $time, got.rdata, m_tma);
         end
         m_tima = got.rdata;
      end
      end_test(4, "timer overflow");

      begin_test();
      bus_write(reg_addr(REG_IF), 8'h00);
      wait_irq_level(1'b0, ok);
      if (!ok) note_failure("irq_valid stayed high after IF was cleared");
      for (int n = 0; n < 8; n++) begin
         r   = rand32();
         ext = r[4:0];
         ie  = r[12:8];
         if ((ext & EXT_MASK) == '0) ext[IRQ_VBLANK] = 1'b1;
         if ((ext & ie & EXT_MASK) == '0) ie = ie | (ext & EXT_MASK);
         pend = ext & ie & EXT_MASK;
         bus_write(reg_addr(REG_IE), {3'b000, ie});
         @(posedge clock_in);
         ext_irq <= ext;
         m_if = m_if | (ext & EXT_MASK);
         wait_irq_level(1'b1, ok);
         if (ok) check_irq(irq_src, lowest_pending(pend));
         else note_failure("irq_valid never rose for a pending enabled source");
         read_and_check(reg_addr(REG_IF));
         @(posedge clock_in);
         ext_irq <= '0;
         bus_write(reg_addr(REG_IF), 8'h00);
         wait_irq_level(1'b0, ok);
         if (!ok) note_failure("irq_valid stayed high after IF was cleared");
      end
      end_test(5, "interrupt priority");

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
+incdir+tb
logic/gbc_bus_pkg.sv
logic/gbc_io_pkg.sv
logic/io_router.sv
logic/timer_unit.sv
logic/interrupt_unit.sv
logic/scratch_regs.sv
logic/gbc_io_top.sv
tb/tb_gbc_io.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_gbc_io
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the result"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
